//--- ucode_defs.svh
// shared widths and encodings for the microcoded stack processor
// include in every RTL file that decodes or sizes instruction fields
`ifndef UCODE_DEFS_SVH
`define UCODE_DEFS_SVH

`define UC_DATA_SZ      16              // word width
`define UC_ADDR_SZ      11              // microcode address width

`define UC_MEM_RNG_UC   3'd0            // microcode read/write
`define UC_MEM_RNG_PC   3'd1            // word at pc, then pc+1
`define UC_MEM_RNG_ERR  3'd2            // reserved, fails the run
`define UC_MEM_RNG_DEV  3'd3            // device registers

`define UC_DEV_OUT      16'h0001        // output strobe address
`define UC_DEV_IN       16'h0003        // level input address

`define UC_ALU_ADD      4'd1
`define UC_ALU_SUB      4'd2
`define UC_ALU_AND      4'd4
`define UC_ALU_XOR      4'd5
`define UC_ALU_OR       4'd6
`define UC_ALU_ROL      4'd7            // rotate left by one
`define UC_ALU_MEM      4'd15           // alu bypass, memory op

`define UC_SE_NONE      3'd0
`define UC_SE_DROP      3'd1
`define UC_SE_PUSH      3'd2
`define UC_SE_RPLC      3'd3
`define UC_SE_SWAP      3'd4
`define UC_SE_ROT       3'd5            // ( a b c -- b c a )
`define UC_SE_DRPL      3'd7            // drop, then replace new top

`define UC_RSTK_DEPTH   8
`define UC_DSTK_DEPTH   8

`endif

//--- ucode_pkg.sv
// instruction word types shared by the sequencer and the ALU
// one 16-bit word, decoded as an evaluation or a control instruction
`include "ucode_defs.svh"

package ucode_pkg;

    // evaluation view; for memory ops alu_a/alu_b carry {wr, rng[2:0]}
    typedef struct packed {
        logic       ctrl;               // 0 here
        logic       exit;               // pop return stack into pc
        logic [1:0] r_op;               // return stack effect
        logic       xdrop;              // extra drop in alu phase
        logic [2:0] d_op;               // data stack effect
        logic [1:0] alu_a;              // left operand select
        logic [1:0] alu_b;              // right operand select
        logic [3:0] alu_op;             // alu function
    } instr_eval_t;

    // control view, jumps, calls and counted branches
    typedef struct packed {
        logic                   ctrl;   // 1 here
        logic                   call;   // push return address
        logic [1:0]             cond;   // 0 always, 2 zero, 1/3 count
        logic                   spare;
        logic [`UC_ADDR_SZ-1:0] target; // jump target
    } instr_ctrl_t;

    typedef union packed {
        instr_eval_t e;
        instr_ctrl_t c;
    } instr_u;

endpackage

//--- ucode_ram_arb.sv
// microcode RAM with one port shared by loader, data access and fetch
// priority is loader, data, fetch; loader only while the CPU is stopped
`timescale 1ns/1ps
`include "ucode_defs.svh"

module ucode_ram_arb (
    input  logic                   i_clk,
    input  logic                   i_load_wr,       // loader write request
    input  logic [`UC_ADDR_SZ-1:0] i_load_addr,
    input  logic [`UC_DATA_SZ-1:0] i_load_data,
    input  logic                   i_running,       // blocks the loader
    input  logic                   i_data_req,      // data access, alu phase
    input  logic                   i_data_wr,
    input  logic [`UC_ADDR_SZ-1:0] i_data_addr,
    input  logic [`UC_DATA_SZ-1:0] i_data_wdata,
    input  logic [`UC_ADDR_SZ-1:0] i_fetch_addr,    // pc
    output logic [`UC_DATA_SZ-1:0] o_rdata          // one cycle after the read
);

    logic [`UC_DATA_SZ-1:0] mem [1 << `UC_ADDR_SZ];  // block ram
    logic                   load_gnt;
    logic                   we;
    logic [`UC_ADDR_SZ-1:0] addr;
    logic [`UC_DATA_SZ-1:0] wdata;

    assign load_gnt = i_load_wr && !i_running;

    // the grant, sole mux ahead of the ram port
    always_comb begin
        if (load_gnt) begin
            we    = 1'b1;
            addr  = i_load_addr;
            wdata = i_load_data;
        end else if (i_data_req) begin
            we    = i_data_wr;
            addr  = i_data_addr;
            wdata = i_data_wdata;
        end else begin
            we    = 1'b0;                           // fetch is read only
            addr  = i_fetch_addr;
            wdata = i_data_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            o_rdata <= mem[addr];                   // no read on a write cycle
        end
    end

endmodule

//--- ucode_stack.sv
// shift-register stack with top two items visible
// applies one stack-effect code per cycle; used for data and return stacks
`timescale 1ns/1ps
`include "ucode_defs.svh"

module ucode_stack #(
    parameter int DEPTH = 8                         // at least 3 for rot
) (
    input  logic                   i_clk,
    input  logic [2:0]             i_se,            // stack effect
    input  logic [`UC_DATA_SZ-1:0] i_data,          // value for push/replace
    output logic [`UC_DATA_SZ-1:0] o_s0,            // top
    output logic [`UC_DATA_SZ-1:0] o_s1             // second
);

    logic [`UC_DATA_SZ-1:0] stk [DEPTH];

    always_ff @(posedge i_clk) begin
        case (i_se)
            `UC_SE_DROP: begin
                for (int i = 0; i < DEPTH - 1; i++) begin
                    stk[i] <= stk[i + 1];           // bottom keeps its value
                end
            end
            `UC_SE_PUSH: begin
                stk[0] <= i_data;
                for (int i = 1; i < DEPTH; i++) begin
                    stk[i] <= stk[i - 1];           // deepest item lost
                end
            end
            `UC_SE_RPLC: stk[0] <= i_data;
            `UC_SE_SWAP: begin
                stk[0] <= stk[1];
                stk[1] <= stk[0];
            end
            `UC_SE_ROT: begin
                stk[0] <= stk[2];                   // third comes to top
                stk[1] <= stk[0];
                stk[2] <= stk[1];
            end
            `UC_SE_DRPL: begin
                stk[0] <= i_data;                   // result over old second
                for (int i = 1; i < DEPTH - 1; i++) begin
                    stk[i] <= stk[i + 1];
                end
            end
            default: ;                              // none, code 6 unused
        endcase
    end

    assign o_s0 = stk[0];
    assign o_s1 = stk[1];

endmodule

//--- ucode_alu.sv
// combinational ALU with operand selection from the instruction word
// control words force an add of d0 and the cond constant (branch counting)
`timescale 1ns/1ps
`include "ucode_defs.svh"

module ucode_alu
    import ucode_pkg::*;
(
    input  instr_u                 i_instr,
    input  logic [`UC_DATA_SZ-1:0] i_d0,
    input  logic [`UC_DATA_SZ-1:0] i_d1,
    input  logic [`UC_DATA_SZ-1:0] i_r0,
    output logic [`UC_DATA_SZ-1:0] o_result
);

    logic [1:0]             sel_a;
    logic [1:0]             sel_b;
    logic [3:0]             op;
    logic [`UC_DATA_SZ-1:0] a;
    logic [`UC_DATA_SZ-1:0] b;

    assign sel_a = i_instr.e.ctrl ? 2'b00 : i_instr.e.alu_a;      // ctrl uses d0
    assign sel_b = i_instr.e.ctrl ? i_instr.c.cond : i_instr.e.alu_b;
    assign op    = i_instr.e.ctrl ? `UC_ALU_ADD : i_instr.e.alu_op;

    always_comb begin
        case (sel_a)
            2'b01:   a = i_d1;
            2'b10:   a = i_r0;
            2'b11:   a = '0;
            default: a = i_d0;
        endcase
        case (sel_b)
            2'b01:   b = `UC_DATA_SZ'(1);           // cond 1 counts up
            2'b10:   b = {1'b1, {(`UC_DATA_SZ-1){1'b0}}};  // msb only
            2'b11:   b = '1;                        // cond 3 counts down
            default: b = i_d0;
        endcase
        case (op)
            `UC_ALU_ADD: o_result = a + b;
            `UC_ALU_SUB: o_result = a - b;
            `UC_ALU_AND: o_result = a & b;
            `UC_ALU_XOR: o_result = a ^ b;
            `UC_ALU_OR:  o_result = a | b;
            `UC_ALU_ROL: o_result = {a[`UC_DATA_SZ-2:0], a[`UC_DATA_SZ-1]};
            default:     o_result = a;              // pass left, also mem bypass
        endcase
    end

endmodule

//--- ucode_sequencer.sv
// two-phase execution engine: pc, decode, stack commands, memory and devices
// alu phase runs memory/pc work of the word just fetched, stack phase commits it
`timescale 1ns/1ps
`include "ucode_defs.svh"

module ucode_sequencer
    import ucode_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_run,
    input  logic [`UC_DATA_SZ-1:0] i_rdata,         // ram read data
    input  logic [`UC_DATA_SZ-1:0] i_alu_result,
    input  logic [`UC_DATA_SZ-1:0] i_d0,
    input  logic [`UC_DATA_SZ-1:0] i_d1,
    input  logic [`UC_DATA_SZ-1:0] i_r0,
    input  logic [`UC_DATA_SZ-1:0] i_in_data,       // device input level
    output logic                   o_running,
    output logic                   o_status,        // 1 ok, 0 failed
    output instr_u                 o_instr,         // word being executed
    output logic [`UC_ADDR_SZ-1:0] o_fetch_addr,
    output logic                   o_data_req,
    output logic                   o_data_wr,
    output logic [`UC_ADDR_SZ-1:0] o_data_addr,
    output logic [`UC_DATA_SZ-1:0] o_data_wdata,
    output logic [2:0]             o_d_se,
    output logic [`UC_DATA_SZ-1:0] o_d_value,
    output logic [2:0]             o_r_se,
    output logic [`UC_DATA_SZ-1:0] o_r_value,
    output logic                   o_out_wr,        // one-cycle strobe
    output logic [`UC_DATA_SZ-1:0] o_out_data
);

    logic                   p_alu;                  // 0 stack phase, 1 alu phase
    logic [`UC_ADDR_SZ-1:0] pc;
    instr_u                 instr_r;
    logic [`UC_DATA_SZ-1:0] in_q;                   // device read, sampled in alu phase
    logic                   ctrl, mem_op, mem_wr, err_rng, d_zero;
    logic                   act_alu, act_stk, out_hit;
    logic [2:0]             mem_rng;

    assign o_running = i_run && o_status;
    assign act_alu   = o_running && p_alu;
    assign act_stk   = o_running && !p_alu;
    assign o_instr   = p_alu ? instr_u'(i_rdata) : instr_r;  // fetched word in alu phase

    assign ctrl    = o_instr.e.ctrl;
    assign mem_op  = !ctrl && (o_instr.e.alu_op == `UC_ALU_MEM);
    assign mem_wr  = o_instr.e.alu_a[1];            // operand bits read as {wr, rng}
    assign mem_rng = {o_instr.e.alu_a[0], o_instr.e.alu_b};
    assign err_rng = (mem_rng == `UC_MEM_RNG_ERR) || mem_rng[2];  // 2 and 4..7
    assign d_zero  = (i_d0 == '0);
    assign out_hit = mem_op && mem_wr && (mem_rng == `UC_MEM_RNG_DEV) && (i_d0 == `UC_DEV_OUT);

    assign o_fetch_addr = pc;
    assign o_data_req   = act_alu && mem_op && (mem_rng == `UC_MEM_RNG_UC);
    assign o_data_wr    = mem_wr;
    assign o_data_addr  = i_d0[`UC_ADDR_SZ-1:0];    // ( cell addr -- )
    assign o_data_wdata = i_d1;

    always_comb begin
        if (mem_op && (mem_rng == `UC_MEM_RNG_UC || mem_rng == `UC_MEM_RNG_PC)) begin
            o_d_value = i_rdata;                    // fetched word or literal
        end else if (mem_op && mem_rng == `UC_MEM_RNG_DEV) begin
            o_d_value = in_q;
        end else begin
            o_d_value = i_alu_result;
        end
    end
    assign o_r_value = ctrl ? {{(`UC_DATA_SZ-`UC_ADDR_SZ){1'b0}}, pc} : o_d_value;

    always_comb begin
        o_d_se = `UC_SE_NONE;
        o_r_se = `UC_SE_NONE;
        if (act_alu) begin
            if (ctrl && o_instr.c.call) begin
                o_r_se = `UC_SE_PUSH;               // return address, pc already +1
            end else if (!ctrl && o_instr.e.xdrop) begin
                o_d_se = `UC_SE_DROP;               // address of a store
            end
        end else if (act_stk) begin
            if (!ctrl) begin
                o_d_se = o_instr.e.d_op;
                o_r_se = {1'b0, o_instr.e.r_op};    // codes 0..3 only
            end else if (o_instr.c.cond == 2'b10) begin
                o_d_se = `UC_SE_DROP;
            end else if (o_instr.c.cond != 2'b00) begin
                o_d_se = d_zero ? `UC_SE_DROP : `UC_SE_RPLC;  // d0 +/- 1
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            p_alu    <= 1'b0;
            pc       <= '0;
            o_status <= 1'b1;
            instr_r  <= '0;                         // nop
            o_out_wr <= 1'b0;
        end else begin
            o_out_wr <= act_alu && out_hit;
            if (act_alu) begin
                if (mem_op && err_rng) begin
                    o_status <= 1'b0;               // sticky until reset
                end
                if (!ctrl && o_instr.e.exit) begin
                    pc <= i_r0[`UC_ADDR_SZ-1:0];    // return
                end else if (mem_op && mem_rng == `UC_MEM_RNG_PC) begin
                    pc <= pc + 1'b1;                // skip the literal
                end else if (ctrl && (o_instr.c.cond == 2'b00 || d_zero)) begin
                    pc <= o_instr.c.target;         // jump, call or taken branch
                end
                instr_r <= o_instr;
                p_alu   <= 1'b0;
            end else if (act_stk) begin
                pc    <= pc + 1'b1;
                p_alu <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (act_alu && mem_op && !mem_wr && mem_rng == `UC_MEM_RNG_DEV) begin
            in_q <= (i_d0 == `UC_DEV_IN) ? i_in_data : '0;  // other addrs read 0
        end
        if (act_alu && out_hit) begin
            o_out_data <= i_d1;                     // second item
        end
    end

endmodule

//--- ucode_cpu.sv
// top level of the microcoded stack processor
// load the program with i_run low, then raise i_run; o_status is valid once o_running falls
`timescale 1ns/1ps
`include "ucode_defs.svh"

module ucode_cpu
    import ucode_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_run,
    input  logic                   i_load_wr,
    input  logic [`UC_ADDR_SZ-1:0] i_load_addr,
    input  logic [`UC_DATA_SZ-1:0] i_load_data,
    input  logic [`UC_DATA_SZ-1:0] i_in_data,
    output logic                   o_running,
    output logic                   o_status,
    output logic                   o_out_wr,
    output logic [`UC_DATA_SZ-1:0] o_out_data
);

    instr_u                 instr;
    logic [`UC_ADDR_SZ-1:0] fetch_addr, data_addr;
    logic                   data_req, data_wr;
    logic [`UC_DATA_SZ-1:0] data_wdata, rdata, alu_result;
    logic [`UC_DATA_SZ-1:0] d0, d1, r0, d_value, r_value;
    logic [2:0]             d_se, r_se;

    ucode_sequencer u_seq (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_run(i_run),
        .i_rdata(rdata), .i_alu_result(alu_result),
        .i_d0(d0), .i_d1(d1), .i_r0(r0), .i_in_data(i_in_data),
        .o_running(o_running), .o_status(o_status), .o_instr(instr),
        .o_fetch_addr(fetch_addr), .o_data_req(data_req), .o_data_wr(data_wr),
        .o_data_addr(data_addr), .o_data_wdata(data_wdata),
        .o_d_se(d_se), .o_d_value(d_value), .o_r_se(r_se), .o_r_value(r_value),
        .o_out_wr(o_out_wr), .o_out_data(o_out_data)
    );

    ucode_ram_arb u_ram (
        .i_clk(i_clk), .i_load_wr(i_load_wr), .i_load_addr(i_load_addr),
        .i_load_data(i_load_data), .i_running(o_running),
        .i_data_req(data_req), .i_data_wr(data_wr), .i_data_addr(data_addr),
        .i_data_wdata(data_wdata), .i_fetch_addr(fetch_addr), .o_rdata(rdata)
    );

    ucode_alu u_alu (
        .i_instr(instr), .i_d0(d0), .i_d1(d1), .i_r0(r0), .o_result(alu_result)
    );

    ucode_stack #(.DEPTH(`UC_DSTK_DEPTH)) u_dstk (      // data stack
        .i_clk(i_clk), .i_se(d_se), .i_data(d_value), .o_s0(d0), .o_s1(d1)
    );

    ucode_stack #(.DEPTH(`UC_RSTK_DEPTH)) u_rstk (      // return stack, top only
        .i_clk(i_clk), .i_se(r_se), .i_data(r_value), .o_s0(r0), .o_s1()
    );

endmodule

//--- ucode_properties.sv
// concurrent checks on the processor top level, attached with bind
// covers the output strobe, sticky status, run gating and loader lockout
`timescale 1ns/1ps

module ucode_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_run,
    input logic i_load_wr,
    input logic o_running,
    input logic o_status,
    input logic o_out_wr
);

    // strobe is a single-cycle pulse
    a_out_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_out_wr |=> !o_out_wr)
        else $error("o_out_wr stayed high for two cycles");

    // status only comes back through reset
    a_status_sticky: assert property (@(posedge i_clk)
        $rose(o_status) |-> $past(!i_rst_n))
        else $error("o_status rose without a reset");

    a_run_gate: assert property (@(posedge i_clk) !i_run |-> !o_running)
        else $error("o_running high while i_run is low");

    a_load_lock: assert property (@(posedge i_clk) !(i_load_wr && o_running))
        else $error("loader write while the processor runs");

endmodule

//--- tb_ucode_cpu.sv
// testbench for the microcoded stack processor
// reads programs and expected outputs from ucode_cases.txt, runs each and checks the strobes
`timescale 1ns/1ps
`include "ucode_defs.svh"

module tb_ucode_cpu;

    logic                   i_clk;
    logic                   i_rst_n;
    logic                   i_run;
    logic                   i_load_wr;
    logic [`UC_ADDR_SZ-1:0] i_load_addr;
    logic [`UC_DATA_SZ-1:0] i_load_data;
    logic [`UC_DATA_SZ-1:0] i_in_data;
    logic                   o_running;
    logic                   o_status;
    logic                   o_out_wr;
    logic [`UC_DATA_SZ-1:0] o_out_data;

    logic [`UC_DATA_SZ-1:0] prog [$];               // image from address 0
    logic [`UC_DATA_SZ-1:0] expect_q [$];
    logic [`UC_DATA_SZ-1:0] got_q [$];
    string                  case_name;
    logic [`UC_DATA_SZ-1:0] in_val;                 // level on i_in_data
    int                     exp_status;
    int                     n_cases;

    ucode_cpu u_ucode_cpu (.*);

    bind ucode_cpu ucode_properties u_props (.*);

    always #4 i_clk = ~i_clk;                       // 8 ns period

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("Error: %s %s expected %h actual %h",
                               case_name, what, exp, act));
        end
    endtask

    // words up to a lone dot; "in" stands for the case input value
    task automatic read_words(input int fd, input bit to_prog);
        string                  tok;
        int                     r;
        logic [`UC_DATA_SZ-1:0] w;
        tok = "";
        while (tok != ".") begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) begin
                tok = ".";                          // eof ends the list
            end else if (tok != ".") begin
                if (tok == "in") begin
                    w = in_val;
                end else begin
                    r = $sscanf(tok, "%h", w);
                end
                if (to_prog) prog.push_back(w);
                else expect_q.push_back(w);
            end
        end
    endtask

    task automatic read_case(input int fd, output bit found);
        string kw;
        string tok;
        int    r;
        found = 1'b0;
        prog.delete();
        expect_q.delete();
        r = 1;
        while (!found && r == 1) begin
            r = $fscanf(fd, "%s", kw);
            if (r == 1) begin
                if (kw == "#") begin
                    r = $fgets(tok, fd);            // comment line
                    r = 1;
                end else if (kw == "case") begin
                    r = $fscanf(fd, "%s %s %d", case_name, tok, exp_status);
                    if (tok == "rand") in_val = 16'($urandom());
                    else r = $sscanf(tok, "%h", in_val);
                    r = 1;
                end else if (kw == "prog") begin
                    read_words(fd, 1'b1);
                end else if (kw == "outs") begin
                    read_words(fd, 1'b0);
                    found = 1'b1;                   // outs closes a case
                end
            end
        end
    endtask

    task automatic reset_and_load();
        @(negedge i_clk);
        i_run     = 1'b0;
        i_rst_n   = 1'b0;
        i_in_data = in_val;
        repeat (2) @(negedge i_clk);
        i_rst_n = 1'b1;
        foreach (prog[i]) begin
            i_load_wr   = 1'b1;
            i_load_addr = i[`UC_ADDR_SZ-1:0];
            i_load_data = prog[i];
            @(negedge i_clk);
        end
        i_load_wr = 1'b0;
    endtask

    task automatic run_and_check();
        int cycles;
        bit done;
        got_q.delete();
        cycles = 0;
        done   = 1'b0;
        i_run  = 1'b1;
        while (!done) begin
            @(negedge i_clk);
            if (o_out_wr) got_q.push_back(o_out_data);  // strobe lasts one cycle
            cycles++;
            if (!o_running) begin
                done = 1'b1;
            end else if (exp_status == 1 && got_q.size() >= expect_q.size()) begin
                done = 1'b1;
            end else if (cycles > 4000) begin
                fail_run($sformatf("timeout in case %s, outputs never arrived", case_name));
            end
        end
        i_run = 1'b0;
        check_value("output count", 32'(expect_q.size()), 32'(got_q.size()));
        foreach (expect_q[i]) begin
            check_value($sformatf("output %0d", i), 32'(expect_q[i]), 32'(got_q[i]));
        end
        check_value("status", 32'(exp_status), 32'(o_status));
    endtask

    initial begin
        int fd;
        bit found;
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_run       = 1'b0;
        i_load_wr   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_in_data   = '0;
        in_val      = '0;
        n_cases     = 0;
        void'($urandom(18885));
        fd          = $fopen("ucode_cases.txt", "r");
        if (fd == 0) begin
            fail_run("could not open ucode_cases.txt");
        end else begin
            found = 1'b1;
            while (found) begin
                read_case(fd, found);
                if (found) begin
                    reset_and_load();
                    run_and_check();
                    n_cases++;
                end
            end
            $fclose(fd);
            if (n_cases == 0) begin
                fail_run("no test cases found in ucode_cases.txt");
            end else begin
                $display("Result: PASSED");
                $finish;
            end
        end
    end

endmodule

//--- ucode_cases.txt
# case <name> <input hex or rand> <final status>, then prog <words from address 0> .
# outs <expected output words in order, in = the input value> .
case alu rand 1
prog 021F 0007 021F 0005 0741 0200 021F 0001 09BF 021F 0003 0742 0200 021F 0001 09BF
     021F 00FC 0744 021F 000F 0745 021F 0030 0746 0307 0200 021F 0001 09BF
     021F 8001 0307 021F 0001 09BF 8024 .
outs 000C 0009 006E 0003 .
case stack rand 1
prog 021F 0001 021F 0002 021F 0003 0500 021F 0001 09BF 0400 021F 0001 09BF
     021F 0004 0240 021F 0001 09BF 021F 0001 09BF 8017 .
outs 0001 0002 0003 0004 .
case mem rand 1
prog 021F ABCD 021F 0100 098F 021F 0100 030F 021F 0001 09BF 800B .
outs ABCD .
case call rand 1
prog C007 021F 0022 021F 0001 09BF 8006 021F 0011 021F 0001 09BF 5000 .
outs 0011 0022 .
case loop rand 1
prog 021F 0004 0200 B00A 0400 021F 0001 09BF 8002 0000 800A .
outs 0004 0003 0002 0001 .
case err rand 0
prog 021F 0005 002F 021F 0001 09BF 8006 .
outs .
case echo rand 1
prog 021F 0003 033F 021F 0001 09BF 8006 .
outs in .

//--- filelist.f
+incdir+.
ucode_pkg.sv
ucode_ram_arb.sv
ucode_stack.sv
ucode_alu.sv
ucode_sequencer.sv
ucode_cpu.sv
ucode_properties.sv
tb_ucode_cpu.sv

//--- Makefile
SIM  := obj_dir/Vtb_ucode_cpu
SRCS := ucode_defs.svh ucode_pkg.sv ucode_ram_arb.sv ucode_stack.sv ucode_alu.sv \
        ucode_sequencer.sv ucode_cpu.sv ucode_properties.sv tb_ucode_cpu.sv

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): $(SRCS) filelist.f
	verilator --binary --assert --top-module tb_ucode_cpu -f filelist.f -o Vtb_ucode_cpu

clean:
	rm -rf obj_dir
